//--- logic/camera_cfg_pkg.sv
// Camera configuration shared definitions
package camera_cfg_pkg;

   // Sensor write address on the bus
   localparam logic [7:0] dev_addr = 8'h78;

   // Entries written after reset
   localparam int init_count = 8;

   // Table index, wide enough for init and strobe entries
   typedef logic [3:0] rom_index_t;

   localparam rom_index_t strobe_on_index  = 4'd8;    // Strobe request on
   localparam rom_index_t strobe_off_index = 4'd9;    // Strobe request off

   // One sensor register write
   typedef struct packed {
      logic [15:0] reg_addr;                          // Sensor register address
      logic [7:0]  reg_value;                         // Data byte
   } write_cmd_t;

   // Sequencer states
   typedef enum logic [1:0] {
      seq_init,                                       // Pushing init entries
      seq_wait_done,                                  // Draining queue and bus
      seq_ready                                       // Serving key events
   } seq_state_t;

   // Bus writer phases, each four clocks per step
   typedef enum logic [2:0] {
      bus_idle,                                       // Lines released high
      bus_start,                                      // SDA falls with SCL high
      bus_bit,                                        // Data bit, MSB first
      bus_ack,                                        // Slave drives ack
      bus_stop                                        // SDA rises with SCL high
   } bus_phase_t;

endpackage

//--- logic/key_debounce.sv
// Push key debounce
`timescale 1ns/1ps

module key_debounce #(
   parameter int debounce_count = 200                 // Stable samples per event
) (
   input  logic clock_20k,
   input  logic camera_rstn,
   input  logic key1,                                 // Raw key, low when pressed
   output logic key_press,                            // One-cycle press pulse
   output logic key_release                           // One-cycle release pulse
);

   localparam int cnt_w = $clog2(debounce_count + 1);
   localparam logic [cnt_w-1:0] cnt_last = cnt_w'(debounce_count - 1);
   localparam logic [cnt_w-1:0] cnt_max  = cnt_w'(debounce_count);

   logic [cnt_w-1:0] low_cnt;                         // Consecutive low samples
   logic [cnt_w-1:0] high_cnt;                        // Consecutive high samples

   always_ff @(posedge clock_20k or negedge camera_rstn) begin
      if (!camera_rstn) begin
         low_cnt     <= '0;
         high_cnt    <= '0;
         key_press   <= 1'b0;
         key_release <= 1'b0;
      end else begin
         if (key1) begin
            low_cnt <= '0;                            // High level breaks low run
            if (high_cnt != cnt_max)
               high_cnt <= high_cnt + 1'b1;           // Saturate at limit
         end else begin
            high_cnt <= '0;                           // Low level breaks high run
            if (low_cnt != cnt_max)
               low_cnt <= low_cnt + 1'b1;
         end
         // Fire once, on the sample that completes the run
         key_press   <= !key1 && (low_cnt == cnt_last);
         key_release <= key1 && (high_cnt == cnt_last);
      end
   end

endmodule

//--- logic/reg_rom.sv
// Sensor register table
`timescale 1ns/1ps

module reg_rom import camera_cfg_pkg::*; (
   input  rom_index_t rom_index,                      // Entry select
   output write_cmd_t rom_cmd                         // Address and value
);

   always_comb begin
      case (rom_index)
         4'd0:    rom_cmd = '{16'h3103, 8'h11};       // Clock from pad
         4'd1:    rom_cmd = '{16'h3008, 8'h82};       // Software reset
         4'd2:    rom_cmd = '{16'h3008, 8'h42};       // Software power down
         4'd3:    rom_cmd = '{16'h3103, 8'h03};       // Clock from PLL
         4'd4:    rom_cmd = '{16'h3017, 8'hff};       // FREX, sync, D[9:6] enable
         4'd5:    rom_cmd = '{16'h3018, 8'hff};       // D[5:0], GPIO enable
         4'd6:    rom_cmd = '{16'h3016, 8'h02};       // Strobe output enable
         4'd7:    rom_cmd = '{16'h3b07, 8'h0a};       // FREX strobe mode 1
         4'd8:    rom_cmd = '{16'h3b00, 8'h83};       // Strobe on, LED3 mode
         4'd9:    rom_cmd = '{16'h3b00, 8'h00};       // Strobe off
         default: rom_cmd = '0;                       // Unused slots
      endcase
   end

endmodule

//--- logic/config_sequencer.sv
// Register configuration sequencer
`timescale 1ns/1ps

module config_sequencer import camera_cfg_pkg::*; (
   input  logic       clock_20k,
   input  logic       camera_rstn,
   input  logic       key_press,                      // Debounced press pulse
   input  logic       key_release,                    // Debounced release pulse
   input  logic       full,                           // Queue has no space
   input  logic       empty,                          // Queue drained
   input  logic       busy,                           // Writer mid-frame
   output logic       push,
   output write_cmd_t push_cmd,
   output logic       reg_conf_done,
   output logic       strobe_flash
);

   localparam rom_index_t last_init = rom_index_t'(init_count - 1);

   seq_state_t state;
   logic       req_valid;                             // Entry waiting for queue space
   rom_index_t req_index;                             // Entry to push

   reg_rom i_reg_rom (
      .rom_index (req_index),
      .rom_cmd   (push_cmd)
   );

   // Held request goes out as soon as the queue has room
   assign push = req_valid && !full;

   always_ff @(posedge clock_20k or negedge camera_rstn) begin
      if (!camera_rstn) begin
         state         <= seq_init;
         req_valid     <= 1'b0;
         req_index     <= '0;
         reg_conf_done <= 1'b0;
         strobe_flash  <= 1'b0;
      end else begin
         case (state)
            seq_init: begin
               if (!req_valid) begin
                  req_valid <= 1'b1;                  // Arm entry 0 after reset
               end else if (push) begin
                  if (req_index == last_init) begin
                     req_valid <= 1'b0;               // All init entries queued
                     state     <= seq_wait_done;
                  end else begin
                     req_index <= rom_index_t'(req_index + 1'b1);
                  end
               end
            end
            seq_wait_done: begin
               // Done once the last frame has left the bus
               if (empty && !busy) begin
                  reg_conf_done <= 1'b1;
                  state         <= seq_ready;
               end
            end
            seq_ready: begin
               if (push)
                  req_valid <= 1'b0;                  // Pending strobe accepted
               if (key_press) begin
                  req_valid    <= 1'b1;
                  req_index    <= strobe_on_index;
                  strobe_flash <= 1'b1;
               end else if (key_release) begin
                  req_valid    <= 1'b1;
                  req_index    <= strobe_off_index;
                  strobe_flash <= 1'b0;
               end
            end
            default: state <= seq_init;
         endcase
      end
   end

endmodule

//--- logic/write_queue.sv
// Write command FIFO
`timescale 1ns/1ps

module write_queue import camera_cfg_pkg::*; #(
   parameter int queue_depth = 4                      // Command slots
) (
   input  logic       clock_20k,
   input  logic       camera_rstn,
   input  logic       push,
   input  write_cmd_t push_cmd,
   input  logic       pop,
   output write_cmd_t head_cmd,                       // Oldest entry
   output logic       full,
   output logic       empty
);

   localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
   localparam int cnt_w = $clog2(queue_depth + 1);
   localparam logic [ptr_w-1:0] ptr_last = ptr_w'(queue_depth - 1);

   write_cmd_t       mem [queue_depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;                           // Occupancy
   logic             wr_en;
   logic             rd_en;

   assign wr_en    = push && !full;
   assign rd_en    = pop && !empty;
   assign full     = (count == cnt_w'(queue_depth));
   assign empty    = (count == '0);
   assign head_cmd = mem[rd_ptr];

   always_ff @(posedge clock_20k) begin
      if (wr_en)
         mem[wr_ptr] <= push_cmd;
   end

   always_ff @(posedge clock_20k or negedge camera_rstn) begin
      if (!camera_rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en)
            wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;    // Wrap at depth
         if (rd_en)
            rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + 1'b1;
         if (wr_en && !rd_en)
            count <= count + 1'b1;
         else if (rd_en && !wr_en)
            count <= count - 1'b1;
      end
   end

endmodule

//--- logic/i2c_writer.sv
// I2C register write serializer
`timescale 1ns/1ps

module i2c_writer import camera_cfg_pkg::*; (
   input  logic       clock_20k,
   input  logic       camera_rstn,
   input  logic       empty,                          // No command waiting
   input  write_cmd_t head_cmd,                       // Next command
   input  logic       i2c_sda_in,                     // Line level for ack
   output logic       pop,
   output logic       busy,
   output logic       i2c_scl,
   output logic       i2c_sda_out,
   output logic       i2c_sda_oe,                     // High drives SDA
   output logic       ack_error                       // Sticky missing ack
);

   bus_phase_t  phase;
   logic [1:0]  quarter;                              // Quarter of current bit
   logic [2:0]  bit_cnt;                              // Bit within byte
   logic [1:0]  byte_cnt;                             // Byte within frame
   logic [31:0] frame;                                // Device, address, value

   assign pop  = (phase == bus_idle) && !empty;       // Take next command when free
   assign busy = (phase != bus_idle);

   // Frame shifter, MSB leads
   always_ff @(posedge clock_20k) begin
      if (pop)
         frame <= {dev_addr, head_cmd};
      else if (phase == bus_bit && quarter == 2'd3)
         frame <= {frame[30:0], 1'b0};
   end

   always_ff @(posedge clock_20k or negedge camera_rstn) begin
      if (!camera_rstn) begin
         phase     <= bus_idle;
         quarter   <= '0;
         bit_cnt   <= '0;
         byte_cnt  <= '0;
         ack_error <= 1'b0;
      end else if (phase == bus_idle) begin
         if (pop) begin
            phase    <= bus_start;
            quarter  <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
         end
      end else begin
         quarter <= quarter + 1'b1;
         // Slave holds SDA low mid-bit for an ack
         if (phase == bus_ack && quarter == 2'd2 && i2c_sda_in)
            ack_error <= 1'b1;
         if (quarter == 2'd3) begin
            case (phase)
               bus_start: phase <= bus_bit;
               bus_bit: begin
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7)
                     phase <= bus_ack;                // Byte sent
               end
               bus_ack: begin
                  byte_cnt <= byte_cnt + 1'b1;
                  phase    <= (byte_cnt == 2'd3) ? bus_stop : bus_bit;
               end
               bus_stop: phase <= bus_idle;
               default:  phase <= bus_idle;
            endcase
         end
      end
   end

   // Line levels per phase and quarter
   always_comb begin
      i2c_scl     = 1'b1;
      i2c_sda_out = 1'b1;
      i2c_sda_oe  = 1'b1;
      case (phase)
         bus_start: begin
            i2c_sda_out = (quarter == 2'd0);          // Falls in quarter 1
            i2c_scl     = (quarter != 2'd3);
         end
         bus_bit: begin
            i2c_sda_out = frame[31];
            i2c_scl     = (quarter == 2'd1) || (quarter == 2'd2);
         end
         bus_ack: begin
            i2c_sda_oe = 1'b0;                        // Release for slave
            i2c_scl    = (quarter == 2'd1) || (quarter == 2'd2);
         end
         bus_stop: begin
            i2c_sda_out = quarter[1];                 // Rises in quarter 2
            i2c_scl     = (quarter != 2'd0);
         end
         default: begin
         end
      endcase
   end

endmodule

//--- logic/camera_config_top.sv
// Camera register configuration top
`timescale 1ns/1ps

module camera_config_top import camera_cfg_pkg::*; (
   input  logic clock_20k,
   input  logic camera_rstn,
   input  logic key1,                                 // Strobe key, low when pressed
   input  logic i2c_sda_in,
   output logic i2c_scl,
   output logic i2c_sda_out,
   output logic i2c_sda_oe,
   output logic reg_conf_done,
   output logic strobe_flash,
   output logic ack_error
);

   localparam int debounce_count = 200;               // About 10 ms at 20 kHz
   localparam int queue_depth    = 4;

   logic       key_press;
   logic       key_release;
   logic       push;
   write_cmd_t push_cmd;
   logic       pop;
   write_cmd_t head_cmd;
   logic       full;
   logic       empty;
   logic       busy;

   key_debounce #(
      .debounce_count (debounce_count)
   ) i_key_debounce (
      .clock_20k   (clock_20k),
      .camera_rstn (camera_rstn),
      .key1        (key1),
      .key_press   (key_press),
      .key_release (key_release)
   );

   config_sequencer i_config_sequencer (
      .clock_20k     (clock_20k),
      .camera_rstn   (camera_rstn),
      .key_press     (key_press),
      .key_release   (key_release),
      .full          (full),
      .empty         (empty),
      .busy          (busy),
      .push          (push),
      .push_cmd      (push_cmd),
      .reg_conf_done (reg_conf_done),
      .strobe_flash  (strobe_flash)
   );

   write_queue #(
      .queue_depth (queue_depth)
   ) i_write_queue (
      .clock_20k   (clock_20k),
      .camera_rstn (camera_rstn),
      .push        (push),
      .push_cmd    (push_cmd),
      .pop         (pop),
      .head_cmd    (head_cmd),
      .full        (full),
      .empty       (empty)
   );

   i2c_writer i_i2c_writer (
      .clock_20k   (clock_20k),
      .camera_rstn (camera_rstn),
      .empty       (empty),
      .head_cmd    (head_cmd),
      .i2c_sda_in  (i2c_sda_in),
      .pop         (pop),
      .busy        (busy),
      .i2c_scl     (i2c_scl),
      .i2c_sda_out (i2c_sda_out),
      .i2c_sda_oe  (i2c_sda_oe),
      .ack_error   (ack_error)
   );

endmodule

//--- tests/camera_config_properties.sv
// Camera configuration bus properties
`timescale 1ns/1ps

module camera_config_properties (
   input logic clock_20k,
   input logic camera_rstn,
   input logic i2c_scl,
   input logic i2c_sda_out,
   input logic i2c_sda_oe,
   input logic i2c_sda_in,
   input logic reg_conf_done,
   input logic push,
   input logic full
);

   logic sda_line;                                    // Resolved bus level
   logic scl_q;
   logic sda_q;
   logic in_frame;                                    // Between start and stop
   logic start_seen;
   logic stop_seen;
   int   fail_count = 0;                              // Failed assertions so far

   assign sda_line   = i2c_sda_oe ? i2c_sda_out : i2c_sda_in;
   assign start_seen = i2c_scl && scl_q && sda_q && !sda_line;    // SDA falls with SCL high
   assign stop_seen  = i2c_scl && scl_q && !sda_q && sda_line;    // SDA rises with SCL high

   always_ff @(posedge clock_20k or negedge camera_rstn) begin
      if (!camera_rstn) begin
         scl_q    <= 1'b1;
         sda_q    <= 1'b1;
         in_frame <= 1'b0;
      end else begin
         scl_q <= i2c_scl;
         sda_q <= sda_line;
         if (start_seen)
            in_frame <= 1'b1;
         else if (stop_seen)
            in_frame <= 1'b0;
      end
   end

   // A fall with SCL high is only legal as a start
   a_start_only: assert property (@(posedge clock_20k) disable iff (!camera_rstn)
      start_seen |-> !in_frame)
      else begin
         fail_count++;
         $error("SDA fell with SCL high inside a frame");
      end

   // A rise with SCL high is only legal as a stop
   a_stop_only: assert property (@(posedge clock_20k) disable iff (!camera_rstn)
      stop_seen |-> in_frame)
      else begin
         fail_count++;
         $error("SDA rose with SCL high outside a frame");
      end

   a_done_held: assert property (@(posedge clock_20k) disable iff (!camera_rstn)
      $past(reg_conf_done) |-> reg_conf_done)
      else begin
         fail_count++;
         $error("reg_conf_done fell after rising");
      end

   a_no_push_full: assert property (@(posedge clock_20k) disable iff (!camera_rstn)
      !(push && full))
      else begin
         fail_count++;
         $error("push while the queue is full");
      end

endmodule

bind camera_config_top camera_config_properties i_properties (
   .clock_20k     (clock_20k),
   .camera_rstn   (camera_rstn),
   .i2c_scl       (i2c_scl),
   .i2c_sda_out   (i2c_sda_out),
   .i2c_sda_oe    (i2c_sda_oe),
   .i2c_sda_in    (i2c_sda_in),
   .reg_conf_done (reg_conf_done),
   .push          (push),
   .full          (full)
);

//--- tests/camera_config_tb.sv
// Camera configuration testbench
`timescale 1ns/1ps

module camera_config_tb;

   logic clock_20k, camera_rstn, key1, i2c_sda_in;
   logic i2c_scl, i2c_sda_out, i2c_sda_oe, reg_conf_done, strobe_flash, ack_error;
   logic sda_line;                                    // Resolved bus level
   logic nack_flag;                                   // Slave refuses acks when set
   integer seed;
   int errors = 0;
   int tests_run = 0;
   int tests_failed = 0;
   int frames_seen = 0;                               // Frames checked so far
   int stops_seen = 0;
   int bit_pos = 0;
   int idx;
   bit in_frame = 1'b0;
   bit scl_prev = 1'b1;
   bit sda_prev = 1'b1;
   bit done_prev = 1'b0;
   logic [31:0] shift;
   logic [31:0] got;
   logic [31:0] want;
   logic [31:0] rx_q[$];                              // Decoded frames
   int exp_q[$];                                      // Expected table indices
   string cur_test = "reset";

   camera_config_top i_dut (.*);

   assign sda_line = i2c_sda_oe ? i2c_sda_out : i2c_sda_in;

   initial begin
      clock_20k = 1'b0;
      forever #50 clock_20k = ~clock_20k;             // 100 ns period
   end

   // Expected frame per table index with device address first
   function automatic logic [31:0] expected_frame(input int index);
      logic [23:0] entry;
      case (index)
         0: entry = 24'h3103_11;
         1: entry = 24'h3008_82;
         2: entry = 24'h3008_42;
         3: entry = 24'h3103_03;
         4: entry = 24'h3017_ff;
         5: entry = 24'h3018_ff;
         6: entry = 24'h3016_02;
         7: entry = 24'h3b07_0a;
         8: entry = 24'h3b00_83;                      // Strobe on
         9: entry = 24'h3b00_00;                      // Strobe off
         default: entry = 24'h0;
      endcase
      return {8'h78, entry};
   endfunction

   // Slave pulls SDA low in ack bits unless refusing
   always @(posedge clock_20k) begin
      #10;
      i2c_sda_in = i2c_sda_oe || nack_flag;
   end

   // Frame decoder sampled mid-cycle where the bus is stable
   always @(negedge clock_20k) begin
      if (scl_prev && i2c_scl && sda_prev && !sda_line) begin
         in_frame = 1'b1;                             // Start
         bit_pos  = 0;
         shift    = '0;
      end else if (scl_prev && i2c_scl && !sda_prev && sda_line && in_frame) begin
         in_frame = 1'b0;                             // Stop
         stops_seen++;
         // 36 bits plus the clock of the stop itself
         assert (bit_pos == 37) else begin
            errors++;
            $display("Error in %s: frame ended after %0d clocks", cur_test, bit_pos);
         end
         rx_q.push_back(shift);
      end else if (in_frame && !scl_prev && i2c_scl) begin
         if (bit_pos < 36 && (bit_pos % 9) != 8)
            shift = {shift[30:0], sda_line};          // Skip ack slots
         bit_pos++;
      end
      if (reg_conf_done && !done_prev) begin
         assert (stops_seen >= 8) else begin
            errors++;
            $display("Error: reg_conf_done rose after only %0d frames", stops_seen);
         end
      end
      done_prev = reg_conf_done;
      scl_prev  = i2c_scl;
      sda_prev  = sda_line;
   end

   // Compare each decoded frame with the next expected entry
   always @(posedge clock_20k) begin
      while (rx_q.size() > 0) begin
         got = rx_q.pop_front();
         frames_seen++;
         assert (exp_q.size() > 0) else begin
            errors++;
            $display("Error in %s: frame %h arrived with none expected", cur_test, got);
         end
         if (exp_q.size() > 0) begin
            idx  = exp_q.pop_front();
            want = expected_frame(idx);
            assert (got == want) else begin
               errors++;
               $display("Mismatch in %s: frame expected %h actual %h", cur_test, want, got);
            end
         end
      end
   end

   task automatic hold_key(input logic level, input int cycles);
      key1 = level;
      repeat (cycles) @(posedge clock_20k);
      #10;
   endtask

   task automatic wait_frames(input int target, input int limit);
      int n;
      n = 0;
      while (frames_seen < target && n < limit) begin
         @(posedge clock_20k);
         #10;
         n++;
      end
      assert (frames_seen >= target) else begin
         errors++;
         $display("Timeout in %s: only %0d of %0d frames seen", cur_test, frames_seen, target);
      end
   endtask

   task automatic wait_done(input int limit);
      int n;
      n = 0;
      while (!reg_conf_done && n < limit) begin
         @(posedge clock_20k);
         #10;
         n++;
      end
      assert (reg_conf_done) else begin
         errors++;
         $display("Timeout in %s: reg_conf_done never rose", cur_test);
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      assert (act === exp) else begin
         errors++;
         $display("Mismatch in %s: %s expected %0b actual %0b", cur_test, what, exp, act);
      end
   endtask

   task automatic check_count(input string what, input int exp, input int act);
      assert (act == exp) else begin
         errors++;
         $display("Mismatch in %s: %s expected %0d actual %0d", cur_test, what, exp, act);
      end
   endtask

   task automatic end_test(input int err_start);
      tests_run++;
      if (errors == err_start) begin
         $display("Test %s passed", cur_test);
      end else begin
         tests_failed++;
         $display("Test %s failed with %0d errors", cur_test, errors - err_start);
      end
   endtask

   initial begin
      int err_start;
      seed        = 71544;
      key1        = 1'b1;                             // Key released
      camera_rstn = 1'b0;
      i2c_sda_in  = 1'b1;
      nack_flag   = 1'b0;
      repeat (5) @(posedge clock_20k);
      #10 camera_rstn = 1'b1;

      cur_test  = "init_frames";
      err_start = errors;
      for (int i = 0; i < 8; i++)
         exp_q.push_back(i);
      hold_key(1'b0, 250);                            // Press lands mid-init
      hold_key(1'b1, 10);
      wait_frames(8, 1600);
      wait_done(50);
      check_count("frame count", 8, frames_seen);
      end_test(err_start);

      cur_test  = "key_during_init";
      err_start = errors;
      hold_key(1'b1, 300);
      check_count("frame count", 8, frames_seen);     // Press left no trace
      check_bit("strobe_flash", 1'b0, strobe_flash);
      end_test(err_start);

      cur_test  = "strobe_on";
      err_start = errors;
      exp_q.push_back(8);
      hold_key(1'b0, 200 + ({$random(seed)} % 100));
      wait_frames(9, 400);
      check_bit("strobe_flash", 1'b1, strobe_flash);
      end_test(err_start);

      cur_test  = "strobe_off";
      err_start = errors;
      exp_q.push_back(9);
      hold_key(1'b1, 200 + ({$random(seed)} % 100));
      wait_frames(10, 400);
      check_bit("strobe_flash", 1'b0, strobe_flash);
      end_test(err_start);

      cur_test  = "key_bounce";
      err_start = errors;
      for (int i = 0; i < 5; i++) begin
         hold_key(1'b0, 5 + ({$random(seed)} % 190));    // Always under 200
         hold_key(1'b1, 20);
      end
      hold_key(1'b1, 100);
      check_count("frame count", 10, frames_seen);
      check_bit("strobe_flash", 1'b0, strobe_flash);
      // Settled high level counts as a fresh release
      exp_q.push_back(9);
      wait_frames(11, 400);
      check_bit("strobe_flash", 1'b0, strobe_flash);
      end_test(err_start);

      cur_test  = "missing_ack";
      err_start = errors;
      check_bit("ack_error", 1'b0, ack_error);
      nack_flag = 1'b1;
      exp_q.push_back(8);
      hold_key(1'b0, 200 + ({$random(seed)} % 100));
      wait_frames(12, 400);
      check_bit("ack_error", 1'b1, ack_error);
      nack_flag = 1'b0;
      exp_q.push_back(9);
      hold_key(1'b1, 200 + ({$random(seed)} % 100));
      wait_frames(13, 400);
      check_bit("ack_error", 1'b1, ack_error);        // Sticky
      check_bit("strobe_flash", 1'b0, strobe_flash);
      end_test(err_start);

      errors += i_dut.i_properties.fail_count;        // Bound bus and status checks
      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

//--- camera_config.f
logic/camera_cfg_pkg.sv
logic/key_debounce.sv
logic/reg_rom.sv
logic/config_sequencer.sv
logic/write_queue.sv
logic/i2c_writer.sv
logic/camera_config_top.sv
tests/camera_config_properties.sv
tests/camera_config_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module camera_config_tb \
   -f camera_config.f -o camera_config_sim || exit 1
out=$(./obj_dir/camera_config_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "^Simulation completed successfully$" && exit 0 || exit 1
